//--- bench/dcache_tb.sv
// Data cache testbench: file driven requests, randomly delayed response acks, response checks
module dcache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import dcache_cfg_pkg::*;
    import dcache_types_pkg::*;

    logic    clk;
    logic    i_rst_n;
    logic    i_req;
    dc_req_t i_req_data;
    logic    o_ack;
    logic    o_rsp_req;
    dc_rsp_t o_rsp_data;
    logic    i_rsp_ack;

    dc_req_t stim_q[$];
    dc_rsp_t exp_q[$];
    int      errors;
    int      rsp_count;
    bit      loaded;

    dcache_top UUT (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_req(i_req),
        .i_req_data(i_req_data),
        .o_ack(o_ack),
        .o_rsp_req(o_rsp_req),
        .o_rsp_data(o_rsp_data),
        .i_rsp_ack(i_rsp_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Each rise of o_rsp_req hands out one response
    always @(posedge o_rsp_req) begin
        rsp_count++;
    end

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, what, actual,
                     expected);
        end
    endtask

    // One request per line, expected response fields follow the stimulus
    task automatic load_testdata();
        int             fd;
        int             n_fields;
        string          line;
        logic [2:0]     op_val;
        logic [31:0]    addr;
        logic [31:0]    wdata;
        logic [127:0]   fill;
        logic           exp_hit;
        logic [31:0]    exp_data;
        logic           exp_vv;
        logic [31:0]    vaddr;
        logic [127:0]   vline;
        dc_req_t        req;
        dc_rsp_t        exp;
        fd = $fopen("bench/dcache_testdata.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h", op_val, addr,
                                       wdata, fill, exp_hit, exp_data, exp_vv, vaddr, vline);
                    if (n_fields != 9) begin
                        errors++;
                        $display("Malformed line in the test data: %s", line);
                    end else begin
                        req              = '0;
                        req.op           = dc_op_e'(op_val);
                        req.addr         = addr;
                        req.data         = wdata;
                        req.fill_line    = fill;
                        exp              = '0;
                        exp.op           = req.op;
                        exp.hit          = exp_hit;
                        exp.data         = exp_data;
                        exp.victim_valid = exp_vv;
                        exp.victim_addr  = vaddr;
                        exp.victim_line  = vline;
                        stim_q.push_back(req);
                        exp_q.push_back(exp);
                    end
                end
            end
            $fclose(fd);
        end
        loaded = (stim_q.size() > 0);
    endtask

    // Four-phase request: raise req, wait for ack, drop req, wait for ack low
    task automatic send_request(input dc_req_t req);
        @(posedge clk);
        i_req_data <= req;
        i_req      <= 1'b1;
        @(negedge clk);
        while (!o_ack) @(negedge clk);
        @(posedge clk);
        i_req <= 1'b0;
        @(negedge clk);
        while (o_ack) @(negedge clk);
    endtask

    task automatic drive_requests();
        foreach (stim_q[i]) begin
            send_request(stim_q[i]);
        end
    endtask

    task automatic compare_response(input int n, input dc_rsp_t exp);
        check_value(128'(o_rsp_data.op), 128'(exp.op), $sformatf("response %0d op", n));
        check_value(128'(o_rsp_data.hit), 128'(exp.hit), $sformatf("response %0d hit", n));
        // Load data only means something on a load hit
        if ((exp.op == OP_LW || exp.op == OP_LB) && exp.hit) begin
            check_value(128'(o_rsp_data.data), 128'(exp.data),
                        $sformatf("response %0d load data", n));
        end
        check_value(128'(o_rsp_data.victim_valid), 128'(exp.victim_valid),
                    $sformatf("response %0d victim valid", n));
        if (exp.victim_valid) begin
            check_value(128'(o_rsp_data.victim_addr), 128'(exp.victim_addr),
                        $sformatf("response %0d victim address", n));
            check_value(o_rsp_data.victim_line, exp.victim_line,
                        $sformatf("response %0d victim line", n));
        end
    endtask

    // Responses are checked in issue order, then acked after 0 to 7 cycles
    task automatic collect_responses();
        int delay;
        for (int n = 0; n < exp_q.size(); n++) begin
            @(negedge clk);
            while (!o_rsp_req) @(negedge clk);
            compare_response(n, exp_q[n]);
            delay = $urandom % 8;
            repeat (delay) @(posedge clk);
            @(posedge clk);
            i_rsp_ack <= 1'b1;
            @(negedge clk);
            while (o_rsp_req) @(negedge clk);
            @(posedge clk);
            i_rsp_ack <= 1'b0;
        end
    endtask

    initial begin
        i_rst_n    = 1'b0;
        i_req      = 1'b0;
        i_req_data = '0;
        i_rsp_ack  = 1'b0;
        errors     = 0;
        rsp_count  = 0;
        loaded     = 1'b0;
        void'($urandom(83410));
        load_testdata();
        if (!loaded) begin
            $display("No request could be read from bench/dcache_testdata.txt");
            $display("Checks failed");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            i_rst_n <= 1'b1;
            @(negedge clk);
            check_value(128'(o_ack), 128'(0), "o_ack after reset");
            check_value(128'(o_rsp_req), 128'(0), "o_rsp_req after reset");
            fork
                drive_requests();
                collect_responses();
            join
            // Nothing more may come out once every request is answered
            repeat (10) @(negedge clk);
            check_value(128'(o_rsp_req), 128'(0), "o_rsp_req after last response");
            check_value(128'(rsp_count), 128'(exp_q.size()), "response count");
            $display("Requests %0d, responses %0d, errors %0d", stim_q.size(), rsp_count,
                     errors);
            if (errors == 0) begin
                $display("All checks passed");
            end else begin
                $display("Checks failed");
            end
            $finish;
        end
    end

    initial begin
        wait (loaded);
        repeat (40 * stim_q.size() + 100) @(posedge clk);
        $display("Timeout: the request sequence did not complete in %0d cycles",
                 40 * stim_q.size() + 100);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- bench/dcache_testdata.txt
# op addr wdata fill_line exp_hit exp_data exp_victim_valid exp_victim_addr exp_victim_line
# ops: 0 LW, 1 LB, 2 SW, 3 SB, 4 FILL; all fields hex
0 00001230 0 0 0 0 0 0 0
4 00001230 0 0f0e0d0c0b0a09080706050403020100 0 0 0 0 0
0 00001230 0 0 1 03020100 0 0 0
0 00001234 0 0 1 07060504 0 0 0
0 00001238 0 0 1 0b0a0908 0 0 0
0 0000123c 0 0 1 0f0e0d0c 0 0 0
3 00001235 000000aa 0 1 0 0 0 0
0 00001234 0 0 1 0706aa04 0 0 0
1 00001235 0 0 1 000000aa 0 0 0
1 00001236 0 0 1 00000006 0 0 0
2 00005670 deadbeef 0 0 0 0 0 0
0 00005670 0 0 0 0 0 0 0
2 00009930 12345678 0 0 0 0 0 0
0 00001230 0 0 1 03020100 0 0 0
4 00009930 0 1f1e1d1c1b1a19181716151413121110 0 0 1 00001230 0f0e0d0c0b0a09080706aa0403020100
0 00009938 0 0 1 1b1a1918 0 0 0
0 00001230 0 0 0 0 0 0 0
4 0000ab30 0 2f2e2d2c2b2a29282726252423222120 0 0 0 0 0
2 0000ab3c cafef00d 0 1 0 0 0 0
0 0000ab3c 0 0 1 cafef00d 0 0 0
3 0000ab3c 00000011 0 1 0 0 0 0
1 0000ab3f 0 0 1 000000ca 0 0 0
0 0000ab3c 0 0 1 cafef011 0 0 0
4 00000030 0 3f3e3d3c3b3a39383736353433323130 0 0 1 0000ab30 cafef0112b2a29282726252423222120
0 00000034 0 0 1 37363534 0 0 0
1 00000107 0 0 0 0 0 0 0
4 00005670 0 4f4e4d4c4b4a49484746454443424140 0 0 0 0 0
0 00000038 0 0 1 3b3a3938 0 0 0
1 0000567d 0 0 1 0000004d 0 0 0

//--- dcache.f
src/dcache_cfg_pkg.sv
src/dcache_types_pkg.sv
src/dcache_req_port.sv
src/dcache_dt.sv
src/dcache_dw.sv
src/dcache_array.sv
src/dcache_rsp_port.sv
src/dcache_top.sv
bench/dcache_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f dcache.f --top-module dcache_tb -o dcache_sim

output=$(./obj_dir/dcache_sim)
echo "$output"

if echo "$output" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

//--- src/dcache_array.sv
// Line array: valid and dirty flops, tag and line storage, registered read and one write port
module dcache_array #(
    parameter int DC_CACHE_SIZE = dcache_cfg_pkg::DC_CACHE_SIZE,
    parameter int DC_LINE_SIZE  = dcache_cfg_pkg::DC_LINE_SIZE
) (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic [dcache_cfg_pkg::dc_index_width(DC_CACHE_SIZE, DC_LINE_SIZE)-1:0] i_rd_index,
    output dcache_types_pkg::dc_line_state_t o_rd_state,
    input  dcache_types_pkg::dc_wr_t         i_wr
);

    import dcache_cfg_pkg::*;

    localparam int IDX_W     = dc_index_width(DC_CACHE_SIZE, DC_LINE_SIZE);
    localparam int NUM_LINES = DC_CACHE_SIZE / DC_LINE_SIZE;

    logic [NUM_LINES-1:0]     valid_q;
    logic [NUM_LINES-1:0]     dirty_q;
    logic [DC_TAG_WIDTH-1:0]  tag_mem [NUM_LINES];
    logic [DC_LINE_WIDTH-1:0] line_mem [NUM_LINES];
    logic                     rd_valid_q;
    logic                     rd_dirty_q;
    logic [DC_TAG_WIDTH-1:0]  rd_tag_q;
    logic [DC_LINE_WIDTH-1:0] rd_line_q;
    logic [IDX_W-1:0]         wr_index;

    assign wr_index = i_wr.index[IDX_W-1:0];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            rd_valid_q <= 1'b0;
            rd_dirty_q <= 1'b0;
        end else begin
            if (i_wr.en) begin
                valid_q[wr_index] <= i_wr.valid;
                dirty_q[wr_index] <= i_wr.dirty;
            end
            // Same-edge write is not seen by this read
            rd_valid_q <= valid_q[i_rd_index];
            rd_dirty_q <= dirty_q[i_rd_index];
        end
    end

    always_ff @(posedge clk) begin
        if (i_wr.en) begin
            tag_mem[wr_index]  <= i_wr.tag;
            line_mem[wr_index] <= i_wr.line;
        end
        rd_tag_q  <= tag_mem[i_rd_index];
        rd_line_q <= line_mem[i_rd_index];
    end

    assign o_rd_state = '{valid: rd_valid_q, dirty: rd_dirty_q, tag: rd_tag_q, line: rd_line_q};

    a_wr_index_known: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_wr.en |-> !$isunknown(i_wr.index));

endmodule

//--- src/dcache_cfg_pkg.sv
// Data cache geometry and the address field widths derived from it
package dcache_cfg_pkg;

    localparam int DC_ADDR_WIDTH     = 32;
    localparam int DC_DATA_WIDTH     = 32;
    localparam int DC_CACHE_SIZE     = 256;
    localparam int DC_LINE_SIZE      = 16;
    localparam int DC_LINE_WIDTH     = DC_LINE_SIZE * 8;
    localparam int DC_BYTE_SEL_WIDTH = DC_DATA_WIDTH / 8;

    // Offset bits pick a byte within one line
    function automatic int dc_offset_width(input int line_size);
        return $clog2(line_size);
    endfunction

    // Index bits pick one line of the direct mapped array
    function automatic int dc_index_width(input int cache_size, input int line_size);
        return $clog2(cache_size / line_size);
    endfunction

    localparam int DC_OFFSET_WIDTH = dc_offset_width(DC_LINE_SIZE);
    localparam int DC_INDEX_WIDTH  = dc_index_width(DC_CACHE_SIZE, DC_LINE_SIZE);
    localparam int DC_TAG_WIDTH    = DC_ADDR_WIDTH - DC_INDEX_WIDTH - DC_OFFSET_WIDTH;

endpackage

//--- src/dcache_dt.sv
// DT stage: address split, array read index, store line placement and stage register
module dcache_dt #(
    parameter int DC_CACHE_SIZE = dcache_cfg_pkg::DC_CACHE_SIZE,
    parameter int DC_LINE_SIZE  = dcache_cfg_pkg::DC_LINE_SIZE
) (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_issue_valid,
    input  dcache_types_pkg::dc_req_t i_issue_req,
    output logic [dcache_cfg_pkg::dc_index_width(DC_CACHE_SIZE, DC_LINE_SIZE)-1:0] o_rd_index,
    output logic                      o_dt_valid,
    output dcache_types_pkg::dc_dt_t  o_dt
);

    import dcache_cfg_pkg::*;
    import dcache_types_pkg::*;

    localparam int OFF_W  = dc_offset_width(DC_LINE_SIZE);
    localparam int IDX_W  = dc_index_width(DC_CACHE_SIZE, DC_LINE_SIZE);
    localparam int TAG_W  = DC_ADDR_WIDTH - IDX_W - OFF_W;
    localparam int BSEL_W = $clog2(DC_BYTE_SEL_WIDTH);

    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] index;
    logic [OFF_W-1:0] offset;
    logic             byte_op;
    dc_dt_t           dt_d;

    // Address is tag, index, offset from the top down
    assign tag    = i_issue_req.addr[DC_ADDR_WIDTH-1 -: TAG_W];
    assign index  = i_issue_req.addr[OFF_W +: IDX_W];
    assign offset = i_issue_req.addr[OFF_W-1:0];

    // Array read starts in the issue cycle
    assign o_rd_index = index;

    assign byte_op = (i_issue_req.op == OP_LB) || (i_issue_req.op == OP_SB);

    always_comb begin
        dt_d.op        = i_issue_req.op;
        dt_d.tag       = tag;
        dt_d.index     = index;
        dt_d.offset    = offset;
        dt_d.fill_line = i_issue_req.fill_line;
        if (byte_op) begin
            dt_d.byte_sel   = DC_BYTE_SEL_WIDTH'(1) << offset[BSEL_W-1:0];
            dt_d.store_line = DC_LINE_WIDTH'(i_issue_req.data[7:0]) << (offset * 8);
        end else begin
            // Word ops ignore the low offset bits
            dt_d.byte_sel   = '1;
            dt_d.store_line = DC_LINE_WIDTH'(i_issue_req.data)
                              << (offset[OFF_W-1:BSEL_W] * DC_DATA_WIDTH);
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_dt_valid <= 1'b0;
        end else begin
            o_dt_valid <= i_issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_issue_valid) begin
            o_dt <= dt_d;
        end
    end

endmodule

//--- src/dcache_dw.sv
// DW stage: hit check, load data, store merge, fill and victim, registered write and response
module dcache_dw #(
    parameter int DC_CACHE_SIZE = dcache_cfg_pkg::DC_CACHE_SIZE,
    parameter int DC_LINE_SIZE  = dcache_cfg_pkg::DC_LINE_SIZE
) (
    input  logic                             clk,
    input  logic                             i_rst_n,
    input  logic                             i_dt_valid,
    input  dcache_types_pkg::dc_dt_t         i_dt,
    input  dcache_types_pkg::dc_line_state_t i_rd_state,
    output dcache_types_pkg::dc_wr_t         o_wr,
    output logic                             o_rsp_valid,
    output dcache_types_pkg::dc_rsp_t        o_rsp
);

    import dcache_cfg_pkg::*;
    import dcache_types_pkg::*;

    localparam int OFF_W  = dc_offset_width(DC_LINE_SIZE);
    localparam int IDX_W  = dc_index_width(DC_CACHE_SIZE, DC_LINE_SIZE);
    localparam int BSEL_W = $clog2(DC_BYTE_SEL_WIDTH);

    dc_line_state_t           cur;
    logic                     bypass;
    logic                     hit;
    logic                     is_load;
    logic                     is_store;
    logic                     is_fill;
    logic [OFF_W-BSEL_W-1:0]  word_sel;
    logic [DC_DATA_WIDTH-1:0] ld_word;
    logic [7:0]               ld_byte;
    logic [DC_LINE_SIZE-1:0]  byte_mask;
    logic [DC_LINE_WIDTH-1:0] merged_line;
    dc_wr_t                   wr_d;
    dc_rsp_t                  rsp_d;

    // The held last write is newer than the array for its index
    assign bypass = (o_wr.index == i_dt.index);
    assign cur    = bypass ? {o_wr.valid, o_wr.dirty, o_wr.tag, o_wr.line} : i_rd_state;

    assign is_load  = (i_dt.op == OP_LW) || (i_dt.op == OP_LB);
    assign is_store = (i_dt.op == OP_SW) || (i_dt.op == OP_SB);
    assign is_fill  = (i_dt.op == OP_FILL);
    assign hit      = cur.valid && (cur.tag == i_dt.tag);

    assign word_sel = i_dt.offset[OFF_W-1:BSEL_W];
    assign ld_word  = cur.line[word_sel * DC_DATA_WIDTH +: DC_DATA_WIDTH];
    assign ld_byte  = cur.line[i_dt.offset * 8 +: 8];

    // Byte enables across the whole line
    assign byte_mask = DC_LINE_SIZE'(i_dt.byte_sel) << (word_sel * DC_BYTE_SEL_WIDTH);

    always_comb begin
        for (int b = 0; b < DC_LINE_SIZE; b++) begin
            merged_line[b*8 +: 8] = byte_mask[b] ? i_dt.store_line[b*8 +: 8]
                                                 : cur.line[b*8 +: 8];
        end
    end

    always_comb begin
        wr_d    = o_wr;
        wr_d.en = 1'b0;
        if (i_dt_valid && is_store && hit) begin
            wr_d.en    = 1'b1;
            wr_d.index = i_dt.index;
            wr_d.tag   = i_dt.tag;
            wr_d.valid = 1'b1;
            wr_d.dirty = 1'b1;
            wr_d.line  = merged_line;
        end else if (i_dt_valid && is_fill) begin
            wr_d.en    = 1'b1;
            wr_d.index = i_dt.index;
            wr_d.tag   = i_dt.tag;
            wr_d.valid = 1'b1;
            wr_d.dirty = 1'b0;
            wr_d.line  = i_dt.fill_line;
        end
    end

    always_comb begin
        rsp_d     = '0;
        rsp_d.op  = i_dt.op;
        rsp_d.hit = hit;
        if (is_load && hit) begin
            rsp_d.data = (i_dt.op == OP_LB) ? DC_DATA_WIDTH'(ld_byte) : ld_word;
        end
        // Only a dirty line has to go back to memory
        if (is_fill && cur.valid && cur.dirty) begin
            rsp_d.victim_valid = 1'b1;
            rsp_d.victim_addr  = {cur.tag, i_dt.index[IDX_W-1:0], {OFF_W{1'b0}}};
            rsp_d.victim_line  = cur.line;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wr        <= '0;
            o_rsp_valid <= 1'b0;
        end else begin
            o_wr        <= wr_d;
            o_rsp_valid <= i_dt_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_dt_valid) begin
            o_rsp <= rsp_d;
        end
    end

    // A valid stage carries one of the five operations
    a_stage_op_legal: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_dt_valid |-> (i_dt.op inside {OP_LW, OP_LB, OP_SW, OP_SB, OP_FILL}));

endmodule

//--- src/dcache_req_port.sv
// Request port: four-phase req/ack handshake, one pipeline issue per handshake
module dcache_req_port (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_req,
    input  dcache_types_pkg::dc_req_t i_req_data,
    output logic                      o_ack,
    input  logic                      i_credit_ok,
    output logic                      o_issue_valid,
    output dcache_types_pkg::dc_req_t o_issue_req
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT
    } state_e;

    state_e state_q;
    state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                // Hold the host off until a response slot is reserved
                if (i_req && i_credit_ok) begin
                    state_d = ST_ISSUE;
                end
            end
            ST_ISSUE: begin
                state_d = ST_WAIT;
            end
            ST_WAIT: begin
                if (!i_req) begin
                    state_d = ST_IDLE;
                end
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Request data is still held by the host during the issue cycle
    assign o_issue_valid = (state_q == ST_ISSUE);
    assign o_issue_req   = i_req_data;
    assign o_ack         = (state_q == ST_WAIT);

    a_req_data_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_req && !o_ack) ##1 (i_req && !o_ack) |-> $stable(i_req_data));

endmodule

//--- src/dcache_rsp_port.sv
// Response port: two-entry response FIFO, credit counter and four-phase response handshake
module dcache_rsp_port (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_issue_valid,
    input  logic                      i_rsp_valid,
    input  dcache_types_pkg::dc_rsp_t i_rsp,
    output logic                      o_credit_ok,
    output logic                      o_rsp_req,
    output dcache_types_pkg::dc_rsp_t o_rsp_data,
    input  logic                      i_rsp_ack
);

    import dcache_types_pkg::*;

    typedef enum logic [1:0] {
        RS_IDLE,
        RS_REQ,
        RS_RELEASE
    } rsp_state_e;

    rsp_state_e state_q;
    dc_rsp_t    buf_q [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic [1:0] credit_q;
    logic       pop;

    // Entry leaves when the host acks and o_rsp_req drops
    assign pop         = (state_q == RS_REQ) && i_rsp_ack;
    assign o_rsp_req   = (state_q == RS_REQ);
    assign o_rsp_data  = buf_q[rd_ptr_q];
    assign o_credit_ok = (credit_q < 2'd2);

    always_ff @(posedge clk) begin
        if (i_rsp_valid) begin
            buf_q[wr_ptr_q] <= i_rsp;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q  <= RS_IDLE;
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= '0;
            credit_q <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q ^ i_rsp_valid;
            rd_ptr_q <= rd_ptr_q ^ pop;
            count_q  <= count_q + 2'(i_rsp_valid) - 2'(pop);
            // Slots reserved at issue, released at pop
            credit_q <= credit_q + 2'(i_issue_valid) - 2'(pop);
            case (state_q)
                RS_IDLE: begin
                    if (count_q != 2'd0) begin
                        state_q <= RS_REQ;
                    end
                end
                RS_REQ: begin
                    if (i_rsp_ack) begin
                        state_q <= RS_RELEASE;
                    end
                end
                default: begin
                    if (!i_rsp_ack) begin
                        state_q <= RS_IDLE;
                    end
                end
            endcase
        end
    end

    a_credit_max: assert property (@(posedge clk) disable iff (!i_rst_n)
        credit_q <= 2'd2);

    a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_rsp_valid |-> count_q < 2'd2);

endmodule

//--- src/dcache_top.sv
// Data cache top level: request port, DT and DW stages, line array and response port
module dcache_top #(
    parameter int DC_CACHE_SIZE = dcache_cfg_pkg::DC_CACHE_SIZE,
    parameter int DC_LINE_SIZE  = dcache_cfg_pkg::DC_LINE_SIZE
) (
    input  logic                      clk,
    input  logic                      i_rst_n,
    input  logic                      i_req,
    input  dcache_types_pkg::dc_req_t i_req_data,
    output logic                      o_ack,
    output logic                      o_rsp_req,
    output dcache_types_pkg::dc_rsp_t o_rsp_data,
    input  logic                      i_rsp_ack
);

    import dcache_cfg_pkg::*;
    import dcache_types_pkg::*;

    localparam int IDX_W = dc_index_width(DC_CACHE_SIZE, DC_LINE_SIZE);

    logic             credit_ok;
    logic             issue_valid;
    dc_req_t          issue_req;
    logic [IDX_W-1:0] rd_index;
    logic             dt_valid;
    dc_dt_t           dt;
    dc_line_state_t   rd_state;
    dc_wr_t           wr;
    logic             rsp_valid;
    dc_rsp_t          rsp;

    dcache_req_port dcache_req_port_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_req(i_req),
        .i_req_data(i_req_data),
        .o_ack(o_ack),
        .i_credit_ok(credit_ok),
        .o_issue_valid(issue_valid),
        .o_issue_req(issue_req)
    );

    dcache_dt #(
        .DC_CACHE_SIZE(DC_CACHE_SIZE),
        .DC_LINE_SIZE(DC_LINE_SIZE)
    ) dcache_dt_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_issue_valid(issue_valid),
        .i_issue_req(issue_req),
        .o_rd_index(rd_index),
        .o_dt_valid(dt_valid),
        .o_dt(dt)
    );

    dcache_dw #(
        .DC_CACHE_SIZE(DC_CACHE_SIZE),
        .DC_LINE_SIZE(DC_LINE_SIZE)
    ) dcache_dw_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_dt_valid(dt_valid),
        .i_dt(dt),
        .i_rd_state(rd_state),
        .o_wr(wr),
        .o_rsp_valid(rsp_valid),
        .o_rsp(rsp)
    );

    dcache_array #(
        .DC_CACHE_SIZE(DC_CACHE_SIZE),
        .DC_LINE_SIZE(DC_LINE_SIZE)
    ) dcache_array_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_rd_index(rd_index),
        .o_rd_state(rd_state),
        .i_wr(wr)
    );

    dcache_rsp_port dcache_rsp_port_inst (
        .clk(clk),
        .i_rst_n(i_rst_n),
        .i_issue_valid(issue_valid),
        .i_rsp_valid(rsp_valid),
        .i_rsp(rsp),
        .o_credit_ok(credit_ok),
        .o_rsp_req(o_rsp_req),
        .o_rsp_data(o_rsp_data),
        .i_rsp_ack(i_rsp_ack)
    );

endmodule

//--- src/dcache_types_pkg.sv
// Data cache transaction types: operation codes, request, pipeline and response records
package dcache_types_pkg;

    import dcache_cfg_pkg::*;

    typedef enum logic [2:0] {
        OP_LW   = 3'd0,
        OP_LB   = 3'd1,
        OP_SW   = 3'd2,
        OP_SB   = 3'd3,
        OP_FILL = 3'd4
    } dc_op_e;

    typedef struct packed {
        dc_op_e                   op;
        logic [DC_ADDR_WIDTH-1:0] addr;
        logic [DC_DATA_WIDTH-1:0] data;
        logic [DC_LINE_WIDTH-1:0] fill_line;
    } dc_req_t;

    // DT to DW pipeline register
    typedef struct packed {
        dc_op_e                       op;
        logic [DC_TAG_WIDTH-1:0]      tag;
        logic [DC_INDEX_WIDTH-1:0]    index;
        logic [DC_OFFSET_WIDTH-1:0]   offset;
        logic [DC_BYTE_SEL_WIDTH-1:0] byte_sel;
        logic [DC_LINE_WIDTH-1:0]     store_line;
        logic [DC_LINE_WIDTH-1:0]     fill_line;
    } dc_dt_t;

    typedef struct packed {
        logic                      en;
        logic [DC_INDEX_WIDTH-1:0] index;
        logic [DC_TAG_WIDTH-1:0]   tag;
        logic                      valid;
        logic                      dirty;
        logic [DC_LINE_WIDTH-1:0]  line;
    } dc_wr_t;

    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [DC_TAG_WIDTH-1:0]  tag;
        logic [DC_LINE_WIDTH-1:0] line;
    } dc_line_state_t;

    typedef struct packed {
        dc_op_e                   op;
        logic                     hit;
        logic [DC_DATA_WIDTH-1:0] data;
        logic                     victim_valid;
        logic [DC_ADDR_WIDTH-1:0] victim_addr;
        logic [DC_LINE_WIDTH-1:0] victim_line;
    } dc_rsp_t;

endpackage
